/* sources.f */
+incdir+testbench
logic/i2c_trace_pkg.sv
logic/i2c_condition_detector.sv
logic/i2c_byte_shifter.sv
logic/i2c_trace_recorder.sv
logic/i2c_debug_monitor.sv
testbench/i2c_debug_tb.sv

/* testbench/i2c_trace_model.svh */
// bus driver tasks, xorshift source and trace reference model, included inside the testbench
`ifndef I2C_TRACE_MODEL_SVH
`define I2C_TRACE_MODEL_SVH

// every bus event in order, trace_clear markers mixed in
trace_entry_t hist_entry[$];
bit           hist_logged[$];
bit           hist_clear[$];
logic [31:0]  rng_state = 32'h9e89;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// an event only lands in the trace while tracing is on
task automatic note_event(input event_kind_t kind, input i2c_byte_t data);
    trace_entry_t e;
    e = {kind, data};
    hist_entry.push_back(e);
    hist_logged.push_back(trace_enable);
    hist_clear.push_back(1'b0);
endtask

task automatic note_clear();
    hist_entry.push_back('0);
    hist_logged.push_back(1'b0);
    hist_clear.push_back(1'b1);
endtask

// inputs move 1 ns after the rising edge
task automatic bus_wait(input int n);
    repeat (n) @(posedge clk);
    #1;
endtask

// 16 clocks per bit, sda only moves while scl is low
task automatic send_bit(input logic b);
    sda = b;
    bus_wait(4);
    scl = 1'b1;
    bus_wait(8);
    scl = 1'b0;
    bus_wait(4);
endtask

// covers both a start from idle and a repeated start
task automatic send_start();
    if (scl == 1'b0) begin
        sda = 1'b1;
        bus_wait(4);
        scl = 1'b1;
        bus_wait(4);
    end
    sda = 1'b0;
    bus_wait(8);
    scl = 1'b0;
    bus_wait(4);
    note_event(ev_start, 8'h00);
endtask

task automatic send_stop();
    sda = 1'b0;
    bus_wait(4);
    scl = 1'b1;
    bus_wait(8);
    sda = 1'b1;
    bus_wait(8);
    note_event(ev_stop, 8'h00);
endtask

// eight data bits msb first, then the ack slot driven low for an ack
task automatic send_byte(input i2c_byte_t data, input logic ack);
    int i;
    for (i = 7; i >= 0; i--) begin
        send_bit(data[i]);
    end
    send_bit(~ack);
    if (ack) begin
        note_event(ev_byte_ack, data);
    end else begin
        note_event(ev_byte_nack, data);
    end
endtask

// replays the history into slot content plus pointer, count, wrap flag and phase
function automatic trace_entry_t predict_trace(input int slot, output int exp_ptr,
                                               output int exp_count, output bit exp_wrapped,
                                               output bus_phase_t exp_phase);
    trace_entry_t slot_val;
    trace_entry_t e;
    event_kind_t  kind;
    int           i;
    slot_val    = '0;
    exp_ptr     = 0;
    exp_count   = 0;
    exp_wrapped = 1'b0;
    exp_phase   = phase_idle;
    for (i = 0; i < hist_entry.size(); i++) begin
        e = hist_entry[i];
        if (hist_clear[i]) begin
            exp_ptr     = 0;
            exp_count   = 0;
            exp_wrapped = 1'b0;
        end else begin
            kind = event_kind_t'(e[ENTRY_W-1:BYTE_W]);
            case (exp_phase)
                phase_idle: begin
                    if (kind == ev_start) begin
                        exp_phase = phase_address;
                    end
                end
                phase_address: begin
                    if (kind == ev_stop) begin
                        exp_phase = phase_idle;
                    end else if (kind == ev_byte_ack || kind == ev_byte_nack) begin
                        exp_phase = phase_data;
                    end
                end
                default: begin
                    if (kind == ev_stop) begin
                        exp_phase = phase_idle;
                    end else if (kind == ev_start) begin
                        exp_phase = phase_address;
                    end
                end
            endcase
            if (hist_logged[i]) begin
                if (exp_ptr == slot) begin
                    slot_val = e;
                end
                // writing into a full trace overwrites the oldest slot
                if (exp_count == TRACE_DEPTH) begin
                    exp_wrapped = 1'b1;
                end else begin
                    exp_count++;
                end
                exp_ptr = (exp_ptr + 1) % TRACE_DEPTH;
            end
        end
    end
    return slot_val;
endfunction

`endif

/* testbench/i2c_debug_tb.sv */
// testbench for the i2c trace monitor, drives bus traffic and checks the trace readout
`timescale 1ns/100ps

module i2c_debug_tb
    import i2c_trace_pkg::*;
;

    localparam int TRACE_DEPTH = 16;
    localparam int PTR_W       = $clog2(TRACE_DEPTH);
    // start, stop and restart count as one bit, a byte as nine
    localparam int BUS_BITS       = 29 + 39 + 22 + 164;
    localparam int TIMEOUT_CYCLES = BUS_BITS * 16 * 2 + 500;

    logic             clk;
    logic             rst_n;
    logic             scl;
    logic             sda;
    logic             trace_enable;
    logic             trace_clear;
    logic [PTR_W-1:0] read_addr;
    trace_entry_t     read_entry;
    logic [PTR_W-1:0] write_ptr;
    logic [PTR_W:0]   entry_count;
    logic             wrapped;
    bus_phase_t       bus_phase;
    int               cycle_cnt;

    i2c_debug_monitor #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .scl          (scl),
        .sda          (sda),
        .trace_enable (trace_enable),
        .trace_clear  (trace_clear),
        .read_addr    (read_addr),
        .read_entry   (read_entry),
        .write_ptr    (write_ptr),
        .entry_count  (entry_count),
        .wrapped      (wrapped),
        .bus_phase    (bus_phase)
    );

    `include "i2c_trace_model.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_entry(input string name, input trace_entry_t exp,
                               input trace_entry_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_phase(input string name, input bus_phase_t exp, input bus_phase_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s phase: expected %s actual %s",
                               name, exp.name(), act.name()));
        end
    endtask

    // registered outputs, stable from 1 ns after the edge
    task automatic check_count(input string name, input logic [PTR_W:0] exp_count,
                               input logic [PTR_W-1:0] exp_ptr, input logic exp_wrapped);
        if (entry_count !== exp_count) begin
            fail_run($sformatf("mismatch %s count: expected %0d actual %0d",
                               name, exp_count, entry_count));
        end
        if (write_ptr !== exp_ptr) begin
            fail_run($sformatf("mismatch %s pointer: expected %0d actual %0d",
                               name, exp_ptr, write_ptr));
        end
        if (wrapped !== exp_wrapped) begin
            fail_run($sformatf("mismatch %s wrapped: expected %b actual %b",
                               name, exp_wrapped, wrapped));
        end
    endtask

    task automatic check_state(input string name);
        int         p;
        int         c;
        bit         w;
        bus_phase_t ph;
        void'(predict_trace(0, p, c, w, ph));
        check_count(name, (PTR_W + 1)'(c), PTR_W'(p), w);
        check_phase(name, ph, bus_phase);
    endtask

    // read_entry is combinational, so sample half a cycle after moving read_addr
    task automatic check_slots(input string name);
        int           slot;
        int           p;
        int           c;
        bit           w;
        bus_phase_t   ph;
        trace_entry_t exp;
        for (slot = 0; slot < TRACE_DEPTH; slot++) begin
            exp = predict_trace(slot, p, c, w, ph);
            read_addr = PTR_W'(slot);
            @(negedge clk);
            check_entry($sformatf("%s slot %0d", name, slot), exp, read_entry);
            bus_wait(1);
        end
    endtask

    task automatic pulse_clear();
        trace_clear = 1'b1;
        note_clear();
        bus_wait(1);
        trace_clear = 1'b0;
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        fail_run($sformatf("timeout: the run did not finish within %0d clock cycles",
                           TIMEOUT_CYCLES));
    end

    initial begin : stimulus
        int i;
        rst_n        = 1'b0;
        scl          = 1'b1;
        sda          = 1'b1;
        trace_enable = 1'b1;
        trace_clear  = 1'b0;
        read_addr    = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        bus_wait(4);
        check_state("after reset");
        check_slots("after reset");

        // single write with the phase followed along the way
        send_start();
        check_phase("write after start", phase_address, bus_phase);
        send_byte(8'ha4, 1'b1);
        check_phase("write after address", phase_data, bus_phase);
        send_byte(8'h3c, 1'b1);
        send_byte(8'h5a, 1'b0);
        send_stop();
        bus_wait(8);
        check_phase("write after stop", phase_idle, bus_phase);
        check_count("single write", 5, 5, 1'b0);
        check_state("single write");
        check_slots("single write");

        // repeated start in the data phase
        send_start();
        send_byte(8'h90, 1'b1);
        send_byte(8'h01, 1'b1);
        check_phase("before restart", phase_data, bus_phase);
        send_start();
        check_phase("after restart", phase_address, bus_phase);
        send_byte(8'h91, 1'b1);
        check_phase("read address", phase_data, bus_phase);
        send_byte(8'he7, 1'b0);
        send_stop();
        bus_wait(8);
        check_state("repeated start");
        check_slots("repeated start");

        // tracing off, phase still follows the bus
        trace_enable = 1'b0;
        send_start();
        check_phase("disabled start", phase_address, bus_phase);
        send_byte(8'h42, 1'b1);
        send_stop();
        bus_wait(8);
        check_state("trace disabled");
        check_slots("trace disabled");
        trace_enable = 1'b1;
        send_start();
        send_byte(8'h43, 1'b0);
        send_stop();
        bus_wait(8);
        check_state("trace resumed");
        check_slots("trace resumed");

        // start, 18 bytes and stop make twenty events from an empty pointer
        pulse_clear();
        check_count("clear before wrap", 0, 0, 1'b0);
        send_start();
        for (i = 0; i < 18; i++) begin
            rng_state = xorshift32(rng_state);
            send_byte(rng_state[7:0], rng_state[8]);
        end
        send_stop();
        bus_wait(8);
        check_count("wraparound", (PTR_W + 1)'(TRACE_DEPTH), PTR_W'(20 % TRACE_DEPTH), 1'b1);
        check_state("wraparound");
        check_slots("wraparound");
        pulse_clear();
        check_count("clear after wrap", 0, 0, 1'b0);
        check_state("clear after wrap");
        check_slots("clear after wrap");

        $display("sim passed");
        $finish;
    end

endmodule

/* logic/i2c_debug_monitor.sv */
// top level of the passive i2c trace monitor, bus lines in and trace readout out
`timescale 1ns/100ps

module i2c_debug_monitor
    import i2c_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          scl,
    input  logic                          sda,
    input  logic                          trace_enable,
    input  logic                          trace_clear,
    input  logic [$clog2(TRACE_DEPTH)-1:0] read_addr,
    output trace_entry_t                  read_entry,
    output logic [$clog2(TRACE_DEPTH)-1:0] write_ptr,
    output logic [$clog2(TRACE_DEPTH):0]   entry_count,
    output logic                          wrapped,
    output bus_phase_t                    bus_phase
);

    logic      scl_s;
    logic      sda_s;
    logic      start_seen;
    logic      stop_seen;
    logic      byte_done;
    i2c_byte_t byte_data;
    logic      byte_ack;

    // lines are synchronized once here and shared with the shifter
    i2c_condition_detector u_detector (
        .clk        (clk),
        .rst_n      (rst_n),
        .scl        (scl),
        .sda        (sda),
        .scl_s      (scl_s),
        .sda_s      (sda_s),
        .start_seen (start_seen),
        .stop_seen  (stop_seen)
    );

    i2c_byte_shifter u_shifter (
        .clk        (clk),
        .rst_n      (rst_n),
        .scl_s      (scl_s),
        .sda_s      (sda_s),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .byte_done  (byte_done),
        .byte_data  (byte_data),
        .byte_ack   (byte_ack)
    );

    i2c_trace_recorder #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) u_recorder (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_seen   (start_seen),
        .stop_seen    (stop_seen),
        .byte_done    (byte_done),
        .byte_data    (byte_data),
        .byte_ack     (byte_ack),
        .trace_enable (trace_enable),
        .trace_clear  (trace_clear),
        .read_addr    (read_addr),
        .read_entry   (read_entry),
        .write_ptr    (write_ptr),
        .entry_count  (entry_count),
        .wrapped      (wrapped),
        .bus_phase    (bus_phase)
    );

endmodule

/* logic/i2c_trace_recorder.sv */
// writes start, stop and byte events into a circular trace memory and tracks the bus phase
`timescale 1ns/100ps

module i2c_trace_recorder
    import i2c_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_seen,
    input  logic                          stop_seen,
    input  logic                          byte_done,
    input  i2c_byte_t                     byte_data,
    input  logic                          byte_ack,
    input  logic                          trace_enable,
    input  logic                          trace_clear,
    input  logic [$clog2(TRACE_DEPTH)-1:0] read_addr,
    output trace_entry_t                  read_entry,
    output logic [$clog2(TRACE_DEPTH)-1:0] write_ptr,
    output logic [$clog2(TRACE_DEPTH):0]   entry_count,
    output logic                          wrapped,
    output bus_phase_t                    bus_phase
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(TRACE_DEPTH);

    trace_entry_t trace_mem [TRACE_DEPTH];
    trace_entry_t new_entry;
    logic         any_event;
    logic         log_event;
    bus_phase_t   phase_next;

    assign any_event = byte_done | start_seen | stop_seen;
    assign log_event = trace_enable & ~trace_clear & any_event;

    // byte strobe wins if strobes ever land together
    always_comb begin
        new_entry = make_entry(ev_stop, '0);
        if (byte_done) begin
            new_entry = make_entry(byte_ack ? ev_byte_ack : ev_byte_nack, byte_data);
        end else if (start_seen) begin
            new_entry = make_entry(ev_start, '0);
        end else if (stop_seen) begin
            new_entry = make_entry(ev_stop, '0);
        end
    end

    // memory starts out cleared, trace_clear leaves contents in place
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TRACE_DEPTH; i++) begin
                trace_mem[i] <= '0;
            end
        end else if (log_event) begin
            trace_mem[write_ptr] <= new_entry;
        end
    end

    assign read_entry = trace_mem[read_addr];

    // pointer wraps on its own width, count saturates at the depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_ptr   <= '0;
            entry_count <= '0;
            wrapped     <= 1'b0;
        end else if (trace_clear) begin
            write_ptr   <= '0;
            entry_count <= '0;
            wrapped     <= 1'b0;
        end else if (log_event) begin
            write_ptr <= write_ptr + 1'b1;
            if (entry_count == FULL_COUNT) begin
                // oldest slot just got overwritten
                wrapped <= 1'b1;
            end else begin
                entry_count <= entry_count + 1'b1;
            end
        end
    end

    // phase follows the bus even with tracing off
    always_comb begin
        phase_next = bus_phase;
        case (bus_phase)
            phase_idle: begin
                if (start_seen) begin
                    phase_next = phase_address;
                end
            end
            phase_address: begin
                if (stop_seen) begin
                    phase_next = phase_idle;
                end else if (byte_done) begin
                    phase_next = phase_data;
                end
            end
            phase_data: begin
                if (stop_seen) begin
                    phase_next = phase_idle;
                end else if (start_seen) begin
                    // repeated start, next byte is an address again
                    phase_next = phase_address;
                end
            end
            default: begin
                phase_next = phase_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_phase <= phase_idle;
        end else begin
            bus_phase <= phase_next;
        end
    end

endmodule

/* logic/i2c_byte_shifter.sv */
// assembles bus bytes on scl rising edges and strobes each byte with its ack bit
`timescale 1ns/100ps

module i2c_byte_shifter
    import i2c_trace_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      scl_s,
    input  logic      sda_s,
    input  logic      start_seen,
    input  logic      stop_seen,
    output logic      byte_done,
    output i2c_byte_t byte_data,
    output logic      byte_ack
);

    // bits 0..7 are data, slot 8 is the acknowledge
    localparam logic [3:0] ACK_SLOT = 4'd8;

    logic       scl_prev;
    logic       scl_rise;
    logic [3:0] bit_cnt;
    i2c_byte_t  shift_q;

    assign scl_rise = scl_s & ~scl_prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_prev <= 1'b1;
        end else begin
            scl_prev <= scl_s;
        end
    end

    // bit framing, restarted by any start or stop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            byte_ack  <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (start_seen || stop_seen) begin
                bit_cnt <= '0;
            end else if (scl_rise) begin
                if (bit_cnt == ACK_SLOT) begin
                    bit_cnt   <= '0;
                    byte_done <= 1'b1;
                    // receiver pulls sda low to acknowledge
                    byte_ack  <= ~sda_s;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // msb first, holds still through the ack slot
    always_ff @(posedge clk) begin
        if (scl_rise && bit_cnt != ACK_SLOT) begin
            shift_q <= {shift_q[BYTE_W-2:0], sda_s};
        end
    end

    assign byte_data = shift_q;

endmodule

/* logic/i2c_condition_detector.sv */
// samples scl and sda into the clock domain and strobes start and stop conditions
`timescale 1ns/100ps

module i2c_condition_detector (
    input  logic clk,
    input  logic rst_n,
    input  logic scl,
    input  logic sda,
    output logic scl_s,
    output logic sda_s,
    output logic start_seen,
    output logic stop_seen
);

    logic scl_meta;
    logic sda_meta;
    logic sda_prev;
    logic sda_fall;
    logic sda_rise;

    // two flops per line, idle bus is high so no edge after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_meta <= 1'b1;
            sda_meta <= 1'b1;
            scl_s    <= 1'b1;
            sda_s    <= 1'b1;
        end else begin
            scl_meta <= scl;
            sda_meta <= sda;
            scl_s    <= scl_meta;
            sda_s    <= sda_meta;
        end
    end

    // previous synchronized sda for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sda_prev <= 1'b1;
        end else begin
            sda_prev <= sda_s;
        end
    end

    assign sda_fall = sda_prev & ~sda_s;
    assign sda_rise = ~sda_prev & sda_s;

    // sda may only move while scl is high for a start or a stop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end else begin
            start_seen <= scl_s & sda_fall;
            stop_seen  <= scl_s & sda_rise;
        end
    end

endmodule

/* logic/i2c_trace_pkg.sv */
// shared types for the i2c trace monitor, imported by the RTL and the testbench
package i2c_trace_pkg;

    // field widths of one trace record
    localparam int BYTE_W  = 8;
    localparam int KIND_W  = 2;
    localparam int ENTRY_W = KIND_W + BYTE_W;

    // one byte as seen on sda, msb first
    typedef logic [BYTE_W-1:0] i2c_byte_t;

    // what a trace slot describes
    typedef enum logic [KIND_W-1:0] {
        ev_start     = 2'd0,
        ev_stop      = 2'd1,
        ev_byte_ack  = 2'd2,
        ev_byte_nack = 2'd3
    } event_kind_t;

    // kind in the top two bits, byte below, zero byte for start and stop
    typedef logic [ENTRY_W-1:0] trace_entry_t;

    // recorder view of where the bus is in a transfer
    typedef enum logic [1:0] {
        phase_idle    = 2'd0,
        phase_address = 2'd1,
        phase_data    = 2'd2
    } bus_phase_t;

    // packs a kind and a byte into the trace record layout
    function automatic trace_entry_t make_entry(event_kind_t kind, i2c_byte_t data);
        trace_entry_t entry;
        entry = {kind, data};
        return entry;
    endfunction

endpackage
